// File: include/stack_core_defines.svh
// --------------------------------------------------
// Stack core widths, depths and opcode values
// Shared by the RTL and the program assembler
// --------------------------------------------------
`ifndef STACK_CORE_DEFINES_SVH
`define STACK_CORE_DEFINES_SVH

// Datapath and memory widths
`define DATA_W     32
`define OPCODE_W   7
`define OPERAND_W  9
`define IADDR_W    9
`define DADDR_W    9
`define IO_IN_W    2
`define IO_OUT_W   2

// Stack depths
`define CALL_DEPTH 8
`define DATA_DEPTH 10

// --------------------------------------------------
// Opcodes
// --------------------------------------------------
`define OP_NOP     7'd0
`define OP_LOD     7'd1
`define OP_PLD     7'd2
`define OP_SET     7'd3
`define OP_PSH     7'd4
`define OP_POP     7'd5
`define OP_ADD     7'd6
`define OP_S_ADD   7'd7
`define OP_AND     7'd8
`define OP_S_AND   7'd9
`define OP_ORR     7'd10
`define OP_S_ORR   7'd11
`define OP_XOR     7'd12
`define OP_S_XOR   7'd13
`define OP_INN     7'd14
`define OP_OUT     7'd15
`define OP_JMP     7'd16
`define OP_JIZ     7'd17
`define OP_CAL     7'd18
`define OP_RET     7'd19

`endif

// File: hw/stack_core_pkg.sv
// --------------------------------------------------
// Stack core types
// Instruction word, ALU selection and per-instruction
// control bundle
// --------------------------------------------------
`include "stack_core_defines.svh"

package stack_core_pkg;

	// Instruction word as delivered by the program ROM
	typedef struct packed {
		logic [`OPCODE_W-1:0]  opcode;
		logic [`OPERAND_W-1:0] operand;
	} instr_t;

	// ALU selections, second operand is b
	typedef enum logic [2:0] {
		pass_b,
		pass_a,
		add,
		and_op,
		orr_op,
		xor_op
	} alu_op_e;

	// --------------------------------------------------
	// Controls produced by decode for one instruction
	// --------------------------------------------------
	typedef struct packed {
		alu_op_e alu_op;
		// Second operand from the data stack
		logic    src_stack;
		// Second operand from the input port
		logic    src_io;
		logic    push;
		logic    pop;
		logic    mem_wr;
		logic    out_en;
		logic    req_in;
	} ctrl_t;

	// Idle control, keeps the accumulator as it is
	localparam ctrl_t ctrl_nop = '{
		alu_op:    pass_a,
		src_stack: 1'b0,
		src_io:    1'b0,
		push:      1'b0,
		pop:       1'b0,
		mem_wr:    1'b0,
		out_en:    1'b0,
		req_in:    1'b0
	};

endpackage

// File: hw/lifo_stack.sv
// --------------------------------------------------
// LIFO stack
// Push writes at the pointer, pop steps it back, top
// always shows the last pushed entry
// --------------------------------------------------
module lifo_stack #(
	parameter int width = 32,
	parameter int depth = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic             pop,
	input  logic [width-1:0] din,
	output logic [width-1:0] top
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

	logic [width-1:0] mem [depth];
	logic [ptr_w-1:0] ptr;
	logic [ptr_w-1:0] ptr_dec;

	// Pointer names the next free slot
	assign ptr_dec = ptr - ptr_w'(1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ptr <= '0;
		else if (push)
			ptr <= ptr + ptr_w'(1);
		else if (pop)
			ptr <= ptr_dec;
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[ptr] <= din;
	end

	assign top = mem[ptr_dec];

endmodule

// File: hw/instr_fetch.sv
// --------------------------------------------------
// Instruction fetch
// Program counter, jump/call/return selection and
// the return-address stack
// --------------------------------------------------
`include "stack_core_defines.svh"

module instr_fetch (
	input  logic                   clk,
	input  logic                   rst,
	input  stack_core_pkg::instr_t instr,
	input  logic                   acc_lsb,
	output logic [`IADDR_W-1:0]    instr_addr
);

	logic [`IADDR_W-1:0] pc;
	logic [`IADDR_W-1:0] ret_addr;
	logic [`IADDR_W-1:0] target;
	logic                is_jmp;
	logic                is_jiz;
	logic                is_cal;
	logic                is_ret;
	logic                load;

	// --------------------------------------------------
	// Branch decision on the word in decode
	// --------------------------------------------------
	assign is_jmp = (instr.opcode == `OP_JMP);
	// JIZ looks at the running value, so no stall is needed
	assign is_jiz = (instr.opcode == `OP_JIZ) && !acc_lsb;
	assign is_cal = (instr.opcode == `OP_CAL) && !rst;
	assign is_ret = (instr.opcode == `OP_RET) && !rst;

	assign load = !rst && (is_jmp || is_jiz || is_cal || is_ret);

	assign target = is_ret ? ret_addr : instr.operand[`IADDR_W-1:0];

	// Redirect in the same cycle, no delay slot
	assign instr_addr = load ? target : pc;

	// --------------------------------------------------
	// Program counter
	// --------------------------------------------------
	// Word 0 is presented in the first two cycles after
	// reset, so programs begin with a NOP
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc <= '0;
		else
			pc <= instr_addr + `IADDR_W'(1);
	end

	// --------------------------------------------------
	// Return addresses
	// --------------------------------------------------
	// pc already points one past the CAL word
	lifo_stack #(
		.width (`IADDR_W),
		.depth (`CALL_DEPTH)
	) u_ret_stack (
		.clk  (clk),
		.rst  (rst),
		.push (is_cal),
		.pop  (is_ret),
		.din  (pc),
		.top  (ret_addr)
	);

endmodule

// File: hw/instr_decode.sv
// --------------------------------------------------
// Instruction decode
// Maps the opcode in decode to the data controls of
// the current cycle
// --------------------------------------------------
`include "stack_core_defines.svh"

module instr_decode (
	input  logic                   rst,
	input  stack_core_pkg::instr_t instr,
	output stack_core_pkg::ctrl_t  ctrl
);

	always_comb begin
		ctrl = stack_core_pkg::ctrl_nop;
		case (instr.opcode)
			// Memory access
			`OP_LOD: ctrl.alu_op = stack_core_pkg::pass_b;
			`OP_PLD: begin
				ctrl.alu_op = stack_core_pkg::pass_b;
				ctrl.push   = 1'b1;
			end
			`OP_SET: ctrl.mem_wr = 1'b1;

			// Data stack
			`OP_PSH: ctrl.push = 1'b1;
			`OP_POP: begin
				ctrl.alu_op    = stack_core_pkg::pass_b;
				ctrl.src_stack = 1'b1;
				ctrl.pop       = 1'b1;
			end

			// Two-operand ALU, memory or stack form
			`OP_ADD: ctrl.alu_op = stack_core_pkg::add;
			`OP_S_ADD: begin
				ctrl.alu_op    = stack_core_pkg::add;
				ctrl.src_stack = 1'b1;
				ctrl.pop       = 1'b1;
			end
			`OP_AND: ctrl.alu_op = stack_core_pkg::and_op;
			`OP_S_AND: begin
				ctrl.alu_op    = stack_core_pkg::and_op;
				ctrl.src_stack = 1'b1;
				ctrl.pop       = 1'b1;
			end
			`OP_ORR: ctrl.alu_op = stack_core_pkg::orr_op;
			`OP_S_ORR: begin
				ctrl.alu_op    = stack_core_pkg::orr_op;
				ctrl.src_stack = 1'b1;
				ctrl.pop       = 1'b1;
			end
			`OP_XOR: ctrl.alu_op = stack_core_pkg::xor_op;
			`OP_S_XOR: begin
				ctrl.alu_op    = stack_core_pkg::xor_op;
				ctrl.src_stack = 1'b1;
				ctrl.pop       = 1'b1;
			end

			// Ports
			`OP_INN: begin
				ctrl.alu_op = stack_core_pkg::pass_b;
				ctrl.src_io = 1'b1;
				ctrl.req_in = 1'b1;
			end
			`OP_OUT: ctrl.out_en = 1'b1;

			// Jumps are handled in fetch
			`OP_NOP, `OP_JMP, `OP_JIZ, `OP_CAL, `OP_RET:
				ctrl = stack_core_pkg::ctrl_nop;
			default:
				ctrl = stack_core_pkg::ctrl_nop;
		endcase

		if (rst)
			ctrl = stack_core_pkg::ctrl_nop;
	end

endmodule

// File: hw/execute_stage.sv
// --------------------------------------------------
// Execute stage
// Data stack, operand registers, ALU and accumulator
// --------------------------------------------------
`include "stack_core_defines.svh"

module execute_stage (
	input  logic                  clk,
	input  logic                  rst,
	input  stack_core_pkg::ctrl_t ctrl,
	input  logic [`DATA_W-1:0]    mem_data_rd,
	input  logic [`DATA_W-1:0]    io_in,
	output logic [`DATA_W-1:0]    result,
	output logic                  acc_lsb
);

	stack_core_pkg::ctrl_t ctrl_q;
	logic [`DATA_W-1:0]    stack_top;
	logic [`DATA_W-1:0]    top_q;
	logic [`DATA_W-1:0]    io_q;
	logic [`DATA_W-1:0]    acc;
	logic [`DATA_W-1:0]    operand_b;
	logic [`DATA_W-1:0]    alu_out;

	// --------------------------------------------------
	// Data stack, driven by decode in cycle n
	// --------------------------------------------------
	// Push stores the running value of the instruction ahead
	lifo_stack #(
		.width (`DATA_W),
		.depth (`DATA_DEPTH)
	) u_data_stack (
		.clk  (clk),
		.rst  (rst),
		.push (ctrl.push),
		.pop  (ctrl.pop),
		.din  (result),
		.top  (stack_top)
	);

	// Decode to execute boundary
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ctrl_q <= stack_core_pkg::ctrl_nop;
		else
			ctrl_q <= ctrl;
	end

	always_ff @(posedge clk) begin
		top_q <= stack_top;
		io_q  <= io_in;
	end

	// --------------------------------------------------
	// ALU
	// --------------------------------------------------
	// Memory data arrives one cycle after the read address
	assign operand_b = ctrl_q.src_io    ? io_q :
	                   ctrl_q.src_stack ? top_q : mem_data_rd;

	always_comb begin
		case (ctrl_q.alu_op)
			stack_core_pkg::pass_a: alu_out = acc;
			stack_core_pkg::add:    alu_out = acc + operand_b;
			stack_core_pkg::and_op: alu_out = acc & operand_b;
			stack_core_pkg::orr_op: alu_out = acc | operand_b;
			stack_core_pkg::xor_op: alu_out = acc ^ operand_b;
			default:                alu_out = operand_b;
		endcase
	end

	// Accumulator
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc <= '0;
		else
			acc <= alu_out;
	end

	assign result  = alu_out;
	assign acc_lsb = alu_out[0];

endmodule

// File: hw/result_port.sv
// --------------------------------------------------
// Result port
// Memory write strobe, input request and the
// registered output strobe
// --------------------------------------------------
`include "stack_core_defines.svh"

module result_port (
	input  logic                  clk,
	input  logic                  rst,
	input  stack_core_pkg::ctrl_t ctrl,
	input  logic [`OPERAND_W-1:0] port,
	output logic                  out_en,
	output logic [`IO_OUT_W-1:0]  addr_out,
	output logic [`IO_IN_W-1:0]   addr_in,
	output logic                  req_in,
	output logic                  mem_wr
);

	// Write and input request belong to the decode cycle
	assign mem_wr  = ctrl.mem_wr;
	assign req_in  = ctrl.req_in;
	assign addr_in = port[`IO_IN_W-1:0];

	// --------------------------------------------------
	// Output strobe, aligned with the executed value
	// --------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			out_en <= 1'b0;
		else
			out_en <= ctrl.out_en;
	end

	always_ff @(posedge clk) begin
		addr_out <= port[`IO_OUT_W-1:0];
	end

endmodule

// File: hw/stack_core.sv
// --------------------------------------------------
// Stack core top level
// Accumulator machine with data and return stacks
// --------------------------------------------------
`include "stack_core_defines.svh"

module stack_core (
	input  logic                   clk,
	input  logic                   rst,
	input  stack_core_pkg::instr_t instr,
	output logic [`IADDR_W-1:0]    instr_addr,
	output logic                   mem_wr,
	output logic [`DADDR_W-1:0]    mem_addr_rd,
	output logic [`DADDR_W-1:0]    mem_addr_wr,
	input  logic [`DATA_W-1:0]     mem_data_rd,
	output logic [`DATA_W-1:0]     mem_data_wr,
	input  logic [`DATA_W-1:0]     io_in,
	output logic [`IO_IN_W-1:0]    addr_in,
	output logic [`IO_OUT_W-1:0]   addr_out,
	output logic                   req_in,
	output logic                   out_en
);

	stack_core_pkg::ctrl_t ctrl;
	logic [`DATA_W-1:0]    result;
	logic                  acc_lsb;

	// --------------------------------------------------
	// Fetch and decode
	// --------------------------------------------------
	instr_fetch u_instr_fetch (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.acc_lsb    (acc_lsb),
		.instr_addr (instr_addr)
	);

	instr_decode u_instr_decode (
		.rst   (rst),
		.instr (instr),
		.ctrl  (ctrl)
	);

	// --------------------------------------------------
	// Execute and results
	// --------------------------------------------------
	execute_stage u_execute_stage (
		.clk         (clk),
		.rst         (rst),
		.ctrl        (ctrl),
		.mem_data_rd (mem_data_rd),
		.io_in       (io_in),
		.result      (result),
		.acc_lsb     (acc_lsb)
	);

	result_port u_result_port (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl),
		.port     (instr.operand),
		.out_en   (out_en),
		.addr_out (addr_out),
		.addr_in  (addr_in),
		.req_in   (req_in),
		.mem_wr   (mem_wr)
	);

	// Operand addresses both memory ports
	assign mem_addr_rd = instr.operand[`DADDR_W-1:0];
	assign mem_addr_wr = instr.operand[`DADDR_W-1:0];
	// SET and OUT both take the running value
	assign mem_data_wr = result;

endmodule

// File: sim/tb_clock.sv
// --------------------------------------------------
// Testbench clock
// Free-running clock of the given period
// --------------------------------------------------
module tb_clock #(
	parameter int period = 20
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

endmodule

// File: sim/tb_stack_core.sv
// --------------------------------------------------
// Stack core testbench
// Program ROM, data memory and port models, directed
// program tests and a watchdog
// --------------------------------------------------
`include "stack_core_defines.svh"

module tb_stack_core;

	localparam int num_tests       = 6;
	localparam int cycles_per_test = 200;

	logic                   clk;
	logic                   rst;
	stack_core_pkg::instr_t instr = '0;
	logic [`IADDR_W-1:0]    instr_addr;
	logic                   mem_wr;
	logic [`DADDR_W-1:0]    mem_addr_rd;
	logic [`DADDR_W-1:0]    mem_addr_wr;
	logic [`DATA_W-1:0]     mem_data_rd = '0;
	logic [`DATA_W-1:0]     mem_data_wr;
	logic [`DATA_W-1:0]     io_in;
	logic [`IO_IN_W-1:0]    addr_in;
	logic [`IO_OUT_W-1:0]   addr_out;
	logic                   req_in;
	logic                   out_en;

	// Memory and port models
	stack_core_pkg::instr_t rom [1 << `IADDR_W];
	logic [`DATA_W-1:0]     dmem [1 << `DADDR_W];
	logic [`DATA_W-1:0]     port_val [1 << `IO_IN_W];
	logic                   load_en;
	logic [`DADDR_W-1:0]    load_addr;
	logic [`DATA_W-1:0]     load_data;
	stack_core_pkg::instr_t halt_word;

	// Observed and expected events
	logic [31:0] out_port_q [$];
	logic [31:0] out_data_q [$];
	logic [31:0] wr_addr_q [$];
	logic [31:0] wr_data_q [$];
	logic [31:0] in_port_q [$];
	logic [31:0] in_data_q [$];
	logic [31:0] exp_port_q [$];
	logic [31:0] exp_data_q [$];
	logic [31:0] exp_wr_addr_q [$];
	logic [31:0] exp_wr_data_q [$];

	tb_clock #(.period (20)) u_tb_clock (.clk (clk));

	stack_core u_stack_core (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_addr  (instr_addr),
		.mem_wr      (mem_wr),
		.mem_addr_rd (mem_addr_rd),
		.mem_addr_wr (mem_addr_wr),
		.mem_data_rd (mem_data_rd),
		.mem_data_wr (mem_data_wr),
		.io_in       (io_in),
		.addr_in     (addr_in),
		.addr_out    (addr_out),
		.req_in      (req_in),
		.out_en      (out_en)
	);

	// --------------------------------------------------
	// Models
	// --------------------------------------------------
	always @(posedge clk) begin
		instr <= rom[instr_addr];
	end

	// Preload port wins over the core write
	always @(posedge clk) begin
		if (load_en)
			dmem[load_addr] <= load_data;
		else if (mem_wr)
			dmem[mem_addr_wr] <= mem_data_wr;
		mem_data_rd <= dmem[mem_addr_rd];
	end

	assign io_in = port_val[addr_in];

	// Event monitor, mid-cycle
	always @(negedge clk) begin
		if (rst) begin
			out_port_q.delete();
			out_data_q.delete();
			wr_addr_q.delete();
			wr_data_q.delete();
			in_port_q.delete();
			in_data_q.delete();
		end else begin
			if (out_en) begin
				out_port_q.push_back(32'(addr_out));
				out_data_q.push_back(mem_data_wr);
			end
			if (mem_wr) begin
				wr_addr_q.push_back(32'(mem_addr_wr));
				wr_data_q.push_back(mem_data_wr);
			end
			if (req_in) begin
				in_port_q.push_back(32'(addr_in));
				in_data_q.push_back(io_in);
			end
		end
	end

	// --------------------------------------------------
	// Program loading and sequencing
	// --------------------------------------------------
	function automatic stack_core_pkg::instr_t encode_instr(
		input logic [`OPCODE_W-1:0]  op,
		input logic [`OPERAND_W-1:0] arg
	);
		stack_core_pkg::instr_t word;
		word.opcode  = op;
		word.operand = arg;
		return word;
	endfunction

	task automatic place_instr(
		input logic [`IADDR_W-1:0]   addr,
		input logic [`OPCODE_W-1:0]  op,
		input logic [`OPERAND_W-1:0] arg
	);
		rom[addr] <= encode_instr(op, arg);
	endtask

	// Self jump ends a program
	task automatic place_halt(input logic [`IADDR_W-1:0] addr);
		halt_word = encode_instr(`OP_JMP, addr);
		rom[addr] <= halt_word;
	endtask

	task automatic preload_word(input logic [`DADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
		load_en   <= 1'b1;
		load_addr <= addr;
		load_data <= data;
		@(posedge clk);
		load_en   <= 1'b0;
	endtask

	task automatic begin_test(input string name);
		$display("Running %s", name);
		@(posedge clk);
		rst <= 1'b1;
		for (int i = 0; i < (1 << `IADDR_W); i++)
			rom[`IADDR_W'(i)] <= '0;
	endtask

	task automatic end_reset();
		repeat (16) @(posedge clk);
		rst <= 1'b0;
	endtask

	// Halt in decode, so every earlier instruction has executed
	// Two more cycles let the last output strobe be recorded
	task automatic wait_done();
		do begin
			@(negedge clk);
		end while (instr !== halt_word);
		repeat (2) @(negedge clk);
	endtask

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
			$display("Testbench failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic compare_outputs();
		check_value("out_count", 32'(out_port_q.size()), 32'(exp_port_q.size()));
		for (int i = 0; i < exp_port_q.size(); i++) begin
			check_value("addr_out", out_port_q[i], exp_port_q[i]);
			check_value("mem_data_wr", out_data_q[i], exp_data_q[i]);
		end
		exp_port_q.delete();
		exp_data_q.delete();
	endtask

	task automatic compare_writes();
		check_value("write_count", 32'(wr_addr_q.size()), 32'(exp_wr_addr_q.size()));
		for (int i = 0; i < exp_wr_addr_q.size(); i++) begin
			check_value("mem_addr_wr", wr_addr_q[i], exp_wr_addr_q[i]);
			check_value("mem_data_wr", wr_data_q[i], exp_wr_data_q[i]);
		end
		exp_wr_addr_q.delete();
		exp_wr_data_q.delete();
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic test_reset_state();
		begin_test("reset state");
		place_halt(9'd1);
		end_reset();
		@(negedge clk);
		check_value("mem_wr", 32'(mem_wr), 32'd0);
		check_value("req_in", 32'(req_in), 32'd0);
		check_value("out_en", 32'(out_en), 32'd0);
		check_value("instr_addr", 32'(instr_addr), 32'd0);
		wait_done();
		compare_outputs();
		compare_writes();
	endtask

	task automatic test_arithmetic();
		logic [31:0] a, b, c, d, e;
		logic [31:0] acc;
		a = $urandom();
		b = $urandom();
		c = $urandom();
		d = $urandom();
		e = $urandom();
		preload_word(9'd10, a);
		preload_word(9'd11, b);
		preload_word(9'd12, c);
		preload_word(9'd13, d);
		preload_word(9'd14, e);
		begin_test("arithmetic");
		place_instr(9'd1, `OP_LOD, 9'd10);
		place_instr(9'd2, `OP_ADD, 9'd11);
		place_instr(9'd3, `OP_AND, 9'd12);
		place_instr(9'd4, `OP_ORR, 9'd13);
		place_instr(9'd5, `OP_XOR, 9'd14);
		place_instr(9'd6, `OP_SET, 9'd20);
		place_instr(9'd7, `OP_OUT, 9'd1);
		place_halt(9'd8);
		end_reset();
		wait_done();
		acc = (((a + b) & c) | d) ^ e;
		exp_wr_addr_q.push_back(32'd20);
		exp_wr_data_q.push_back(acc);
		exp_port_q.push_back(32'd1);
		exp_data_q.push_back(acc);
		compare_outputs();
		compare_writes();
	endtask

	task automatic test_stack();
		logic [31:0] a, b, c;
		logic [31:0] acc;
		logic [31:0] model_stack [$];
		a = $urandom();
		b = $urandom();
		c = $urandom();
		preload_word(9'd10, a);
		preload_word(9'd11, b);
		preload_word(9'd12, c);
		begin_test("data stack");
		place_instr(9'd1, `OP_LOD, 9'd10);
		place_instr(9'd2, `OP_PSH, 9'd0);
		place_instr(9'd3, `OP_PLD, 9'd11);
		place_instr(9'd4, `OP_PLD, 9'd12);
		place_instr(9'd5, `OP_S_ADD, 9'd0);
		place_instr(9'd6, `OP_OUT, 9'd0);
		place_instr(9'd7, `OP_S_XOR, 9'd0);
		place_instr(9'd8, `OP_OUT, 9'd1);
		place_instr(9'd9, `OP_POP, 9'd0);
		place_instr(9'd10, `OP_OUT, 9'd2);
		place_halt(9'd11);
		end_reset();
		wait_done();
		// Reference stack, PLD pushes the old accumulator
		acc = a;
		model_stack.push_back(acc);
		model_stack.push_back(acc);
		acc = b;
		model_stack.push_back(acc);
		acc = c;
		acc = acc + model_stack.pop_back();
		exp_port_q.push_back(32'd0);
		exp_data_q.push_back(acc);
		acc = acc ^ model_stack.pop_back();
		exp_port_q.push_back(32'd1);
		exp_data_q.push_back(acc);
		acc = model_stack.pop_back();
		exp_port_q.push_back(32'd2);
		exp_data_q.push_back(acc);
		compare_outputs();
		compare_writes();
	endtask

	task automatic test_control_flow();
		logic [31:0] even_val, odd_val;
		even_val = $urandom();
		even_val[0] = 1'b0;
		odd_val = $urandom();
		odd_val[0] = 1'b1;
		preload_word(9'd10, even_val);
		preload_word(9'd11, odd_val);
		begin_test("control flow");
		place_instr(9'd1, `OP_LOD, 9'd10);
		place_instr(9'd2, `OP_JMP, 9'd4);
		place_instr(9'd3, `OP_OUT, 9'd3);
		place_instr(9'd4, `OP_OUT, 9'd0);
		place_instr(9'd5, `OP_JIZ, 9'd7);
		place_instr(9'd6, `OP_OUT, 9'd3);
		place_instr(9'd7, `OP_LOD, 9'd11);
		place_instr(9'd8, `OP_JIZ, 9'd10);
		place_instr(9'd9, `OP_OUT, 9'd1);
		place_instr(9'd10, `OP_OUT, 9'd2);
		place_halt(9'd11);
		end_reset();
		wait_done();
		exp_port_q.push_back(32'd0);
		exp_data_q.push_back(even_val);
		exp_port_q.push_back(32'd1);
		exp_data_q.push_back(odd_val);
		exp_port_q.push_back(32'd2);
		exp_data_q.push_back(odd_val);
		compare_outputs();
		compare_writes();
	endtask

	task automatic test_call_return();
		logic [31:0] a;
		logic [31:0] path [6];
		a = $urandom();
		preload_word(9'd10, a);
		begin_test("call and return");
		place_instr(9'd1, `OP_LOD, 9'd10);
		place_instr(9'd2, `OP_CAL, 9'd10);
		place_instr(9'd3, `OP_OUT, 9'd0);
		place_halt(9'd4);
		// Three nested levels, ports 1 to 3
		place_instr(9'd10, `OP_OUT, 9'd1);
		place_instr(9'd11, `OP_CAL, 9'd20);
		place_instr(9'd12, `OP_OUT, 9'd1);
		place_instr(9'd13, `OP_RET, 9'd0);
		place_instr(9'd20, `OP_OUT, 9'd2);
		place_instr(9'd21, `OP_CAL, 9'd30);
		place_instr(9'd22, `OP_OUT, 9'd2);
		place_instr(9'd23, `OP_RET, 9'd0);
		place_instr(9'd30, `OP_OUT, 9'd3);
		place_instr(9'd31, `OP_RET, 9'd0);
		end_reset();
		wait_done();
		// Ports on the way down, then on the way back up
		path = '{32'd1, 32'd2, 32'd3, 32'd2, 32'd1, 32'd0};
		foreach (path[k]) begin
			exp_port_q.push_back(path[k]);
			exp_data_q.push_back(a);
		end
		compare_outputs();
		compare_writes();
	endtask

	task automatic test_ports();
		logic [31:0] pv [4];
		begin_test("ports");
		for (int i = 0; i < 4; i++) begin
			pv[2'(i)] = {2'(i), 30'($urandom())};
			port_val[2'(i)] <= pv[2'(i)];
			place_instr(`IADDR_W'(1 + 2 * i), `OP_INN, `OPERAND_W'(i));
			place_instr(`IADDR_W'(2 + 2 * i), `OP_OUT, `OPERAND_W'(i));
		end
		place_halt(9'd9);
		end_reset();
		wait_done();
		check_value("in_count", 32'(in_port_q.size()), 32'd4);
		for (int i = 0; i < 4; i++) begin
			check_value("addr_in", in_port_q[i], 32'(i));
			check_value("io_in", in_data_q[i], pv[2'(i)]);
			exp_port_q.push_back(32'(i));
			exp_data_q.push_back(pv[2'(i)]);
		end
		compare_outputs();
		compare_writes();
	endtask

	// --------------------------------------------------
	// Main sequence and watchdog
	// --------------------------------------------------
	initial begin
		void'($urandom(24));
		rst       <= 1'b1;
		load_en   <= 1'b0;
		load_addr <= '0;
		load_data <= '0;
		for (int i = 0; i < 4; i++)
			port_val[2'(i)] <= '0;
		halt_word  = '0;
		test_reset_state();
		test_arithmetic();
		test_stack();
		test_control_flow();
		test_call_return();
		test_ports();
		$display("Testbench passed");
		$finish;
	end

	initial begin
		repeat (num_tests * cycles_per_test) @(posedge clk);
		$display("Testbench failed");
		$fatal(1, "Timeout after %0d cycles, a program never reached its halt",
			num_tests * cycles_per_test);
	end

endmodule

// File: stack_core.f
+incdir+include
hw/stack_core_pkg.sv
hw/lifo_stack.sv
hw/instr_fetch.sv
hw/instr_decode.sv
hw/execute_stage.sv
hw/result_port.sv
hw/stack_core.sv
sim/tb_clock.sv
sim/tb_stack_core.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the stack core testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module tb_stack_core -f stack_core.f \
	&& ./obj_dir/Vtb_stack_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qsx "Testbench passed" sim.log && echo "Simulation PASS" && exit 0 \
	|| { echo "Simulation FAIL"; exit 1; }
